/* logic/isaPkg.sv */
`default_nettype none

package isaPkg;

   ////////////////////////////////////////////////////////////
   // Widths
   ////////////////////////////////////////////////////////////
   localparam int dataW   = 16;
   localparam int regIdxW = 3;
   localparam int opW     = 5;

   // JAL and JALR always link into r7
   localparam logic [regIdxW-1:0] linkReg = 3'd7;

   ////////////////////////////////////////////////////////////
   // Encodings
   ////////////////////////////////////////////////////////////
   // Full five-bit opcode map, instruction bits 15..11
   typedef enum logic [opW-1:0] {
      opHalt   = 5'b00000, opNop    = 5'b00001, opSiic   = 5'b00010, opRti    = 5'b00011,
      opJ      = 5'b00100, opJr     = 5'b00101, opJal    = 5'b00110, opJalr   = 5'b00111,
      opAddi   = 5'b01000, opSubi   = 5'b01001, opXori   = 5'b01010, opAndni  = 5'b01011,
      opBeqz   = 5'b01100, opBnez   = 5'b01101, opBltz   = 5'b01110, opBgez   = 5'b01111,
      opSt     = 5'b10000, opLd     = 5'b10001, opSlbi   = 5'b10010, opStu    = 5'b10011,
      opRoli   = 5'b10100, opSlli   = 5'b10101, opRori   = 5'b10110, opSrli   = 5'b10111,
      opLbi    = 5'b11000, opBtr    = 5'b11001, opRshift = 5'b11010, opRformat = 5'b11011,
      opSeq    = 5'b11100, opSlt    = 5'b11101, opSle    = 5'b11110, opSco    = 5'b11111
   } opcodeT;

   typedef enum logic [3:0] {
      aluAdd, aluXor, aluAndn, aluRol, aluSll, aluRor, aluSrl,
      aluSeq, aluSlt, aluSle, aluSco, aluPassB
   } aluOpT;

   // Operand B source, bShiftedRs is (Rs << 8) | zext(imm8) for SLBI
   typedef enum logic [1:0] {bRegRt, bImm5, bImm8, bShiftedRs} bSrcT;

   // Write-back source, link is PC+2, rev is bit-reversed Rs
   typedef enum logic [1:0] {wbAlu, wbLink, wbRev} wbSrcT;

   // Destination field, rd 4..2, rs 10..8, rt 7..5, or r7
   typedef enum logic [1:0] {dstRd, dstRs, dstRt, dstLink} dstSelT;

   typedef enum logic [2:0] {
      brNever, brEqz, brNez, brLtz, brGez, brAlways, brReg
   } brCondT;

   ////////////////////////////////////////////////////////////
   // Pipeline structs
   ////////////////////////////////////////////////////////////
   typedef struct packed {
      aluOpT  aluOp;
      logic   invA;
      logic   invB;
      logic   cin;
      bSrcT   bSrc;
      logic   zeroExt;
      wbSrcT  wbSrc;
      dstSelT dstSel;
      logic   regWrt;
      brCondT brCond;
      // J and JAL take the 11-bit displacement
      logic   longImm;
      logic   unsupported;
   } ctrlT;

   typedef struct packed {
      logic             valid;
      logic [dataW-1:0] pc;
      logic [dataW-1:0] instr;
   } instrInT;

   typedef struct packed {
      logic               valid;
      logic [dataW-1:0]   pc;
      ctrlT               ctrl;
      logic [regIdxW-1:0] rsIdx;
      logic [regIdxW-1:0] rtIdx;
      logic [regIdxW-1:0] dstIdx;
      logic [dataW-1:0]   rsData;
      logic [dataW-1:0]   rtData;
      // Immediates already extended to full width
      logic [dataW-1:0]   imm5;
      logic [dataW-1:0]   imm8;
      logic [dataW-1:0]   imm11;
   } decodedT;

   typedef struct packed {
      logic               valid;
      logic [regIdxW-1:0] regIdx;
      logic [dataW-1:0]   data;
   } wbT;

   typedef struct packed {
      logic             valid;
      logic [dataW-1:0] target;
   } redirectT;

endpackage

`default_nettype wire

/* logic/controlDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module controlDecoder (
   input  isaPkg::opcodeT opcode,
   input  logic [1:0]     funct,
   output isaPkg::ctrlT   ctrl
);

   // Shift group encoding shared by immediate and register forms
   function automatic isaPkg::aluOpT shiftOp(input logic [1:0] sel);
      case (sel)
         2'b00:   return isaPkg::aluRol;
         2'b01:   return isaPkg::aluSll;
         2'b10:   return isaPkg::aluRor;
         default: return isaPkg::aluSrl;
      endcase
   endfunction

   always_comb begin
      // Defaults describe a NOP
      ctrl.aluOp       = isaPkg::aluAdd;
      ctrl.invA        = 1'b0;
      ctrl.invB        = 1'b0;
      ctrl.cin         = 1'b0;
      ctrl.bSrc        = isaPkg::bRegRt;
      ctrl.zeroExt     = 1'b0;
      ctrl.wbSrc       = isaPkg::wbAlu;
      ctrl.dstSel      = isaPkg::dstRd;
      ctrl.regWrt      = 1'b0;
      ctrl.brCond      = isaPkg::brNever;
      ctrl.longImm     = 1'b0;
      ctrl.unsupported = 1'b0;

      case (opcode)
         ////////////////////////////////////////////////////////////
         // Immediate ALU group, result to bits 7..5
         ////////////////////////////////////////////////////////////
         isaPkg::opAddi, isaPkg::opSubi, isaPkg::opXori, isaPkg::opAndni: begin
            ctrl.bSrc   = isaPkg::bImm5;
            ctrl.dstSel = isaPkg::dstRt;
            ctrl.regWrt = 1'b1;
            // SUBI is imm - Rs
            if (opcode == isaPkg::opSubi) begin
               ctrl.invA = 1'b1;
               ctrl.cin  = 1'b1;
            end
            if (opcode == isaPkg::opXori) ctrl.aluOp = isaPkg::aluXor;
            if (opcode == isaPkg::opAndni) ctrl.aluOp = isaPkg::aluAndn;
            // Only the logic immediates zero-extend
            ctrl.zeroExt = (opcode == isaPkg::opXori) || (opcode == isaPkg::opAndni);
         end
         isaPkg::opRoli, isaPkg::opSlli, isaPkg::opRori, isaPkg::opSrli: begin
            ctrl.aluOp  = shiftOp(opcode[1:0]);
            ctrl.bSrc   = isaPkg::bImm5;
            ctrl.dstSel = isaPkg::dstRt;
            ctrl.regWrt = 1'b1;
         end

         ////////////////////////////////////////////////////////////
         // Register ALU group and compares, result to bits 4..2
         ////////////////////////////////////////////////////////////
         isaPkg::opRformat: begin
            ctrl.regWrt = 1'b1;
            case (funct)
               2'b00: ctrl.aluOp = isaPkg::aluAdd;
               // SUB is Rt - Rs
               2'b01: begin
                  ctrl.invA = 1'b1;
                  ctrl.cin  = 1'b1;
               end
               2'b10: ctrl.aluOp = isaPkg::aluXor;
               default: ctrl.aluOp = isaPkg::aluAndn;
            endcase
         end
         isaPkg::opRshift: begin
            ctrl.aluOp  = shiftOp(funct);
            ctrl.regWrt = 1'b1;
         end
         isaPkg::opSeq, isaPkg::opSco: begin
            ctrl.aluOp  = (opcode == isaPkg::opSeq) ? isaPkg::aluSeq : isaPkg::aluSco;
            ctrl.regWrt = 1'b1;
         end
         // Signed compares run Rs - Rt through the adder
         isaPkg::opSlt, isaPkg::opSle: begin
            ctrl.aluOp  = (opcode == isaPkg::opSlt) ? isaPkg::aluSlt : isaPkg::aluSle;
            ctrl.invB   = 1'b1;
            ctrl.cin    = 1'b1;
            ctrl.regWrt = 1'b1;
         end

         // Byte loads and bit reverse
         isaPkg::opLbi, isaPkg::opSlbi: begin
            ctrl.aluOp   = isaPkg::aluPassB;
            ctrl.bSrc    = (opcode == isaPkg::opLbi) ? isaPkg::bImm8 : isaPkg::bShiftedRs;
            ctrl.zeroExt = (opcode == isaPkg::opSlbi);
            ctrl.dstSel  = isaPkg::dstRs;
            ctrl.regWrt  = 1'b1;
         end
         isaPkg::opBtr: begin
            ctrl.wbSrc  = isaPkg::wbRev;
            ctrl.regWrt = 1'b1;
         end

         ////////////////////////////////////////////////////////////
         // Control transfer
         ////////////////////////////////////////////////////////////
         isaPkg::opBeqz, isaPkg::opBnez, isaPkg::opBltz, isaPkg::opBgez: begin
            ctrl.bSrc = isaPkg::bImm8;
            case (opcode[1:0])
               2'b00:   ctrl.brCond = isaPkg::brEqz;
               2'b01:   ctrl.brCond = isaPkg::brNez;
               2'b10:   ctrl.brCond = isaPkg::brLtz;
               default: ctrl.brCond = isaPkg::brGez;
            endcase
         end
         isaPkg::opJ, isaPkg::opJal: begin
            ctrl.longImm = 1'b1;
            ctrl.brCond  = isaPkg::brAlways;
         end
         isaPkg::opJr, isaPkg::opJalr: begin
            ctrl.bSrc   = isaPkg::bImm8;
            ctrl.brCond = isaPkg::brReg;
         end

         // Memory and exception ops have no datapath here
         isaPkg::opSt, isaPkg::opLd, isaPkg::opStu, isaPkg::opSiic, isaPkg::opRti:
            ctrl.unsupported = 1'b1;

         default: ;
      endcase

      // Linking jumps write PC+2 into r7
      if (opcode == isaPkg::opJal || opcode == isaPkg::opJalr) begin
         ctrl.wbSrc  = isaPkg::wbLink;
         ctrl.dstSel = isaPkg::dstLink;
         ctrl.regWrt = 1'b1;
      end

      // An unsupported op must never reach the write port
      assert (!(ctrl.unsupported && ctrl.regWrt));
   end

endmodule

`default_nettype wire

/* logic/regFile.sv */
`timescale 1ns/1ps
`default_nettype none

module regFile (
   input  logic                        clk,
   input  logic                        rstN,
   input  logic [isaPkg::regIdxW-1:0]  rdIdxA,
   input  logic [isaPkg::regIdxW-1:0]  rdIdxB,
   output logic [isaPkg::dataW-1:0]    rdDataA,
   output logic [isaPkg::dataW-1:0]    rdDataB,
   input  isaPkg::wbT                  wr
);

   logic [isaPkg::dataW-1:0] regs [8];

   // All eight registers read zero out of reset
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         regs <= '{default: '0};
      end else if (wr.valid) begin
         regs[wr.regIdx] <= wr.data;
      end
   end

   // Plain asynchronous reads
   // Same-cycle results are forwarded in execute
   assign rdDataA = regs[rdIdxA];
   assign rdDataB = regs[rdIdxB];

   // A valid write coming from execute must name a known register
   wrIdxKnown: assert property (@(posedge clk) disable iff (!rstN)
      wr.valid |-> !$isunknown(wr.regIdx));

endmodule

`default_nettype wire

/* logic/decodeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
   input  logic                        clk,
   input  logic                        rstN,
   input  isaPkg::instrInT             instrIn,
   output logic [isaPkg::regIdxW-1:0]  rdIdxA,
   output logic [isaPkg::regIdxW-1:0]  rdIdxB,
   input  logic [isaPkg::dataW-1:0]    rdDataA,
   input  logic [isaPkg::dataW-1:0]    rdDataB,
   output isaPkg::decodedT             decoded
);

   logic [isaPkg::dataW-1:0]   instr;
   isaPkg::opcodeT             opcode;
   isaPkg::ctrlT               ctrl;
   logic [isaPkg::dataW-1:0]   imm5Ext;
   logic [isaPkg::dataW-1:0]   imm8Ext;
   logic [isaPkg::dataW-1:0]   imm11Ext;
   logic [isaPkg::regIdxW-1:0] dstIdx;
   isaPkg::decodedT            slotQ;

   assign instr  = instrIn.instr;
   assign opcode = isaPkg::opcodeT'(instr[15:11]);

   controlDecoder uCtrl (
      .opcode (opcode),
      .funct  (instr[1:0]),
      .ctrl   (ctrl)
   );

   ////////////////////////////////////////////////////////////
   // Immediate extension
   ////////////////////////////////////////////////////////////
   assign imm5Ext  = ctrl.zeroExt ? {11'h000, instr[4:0]} : {{11{instr[4]}}, instr[4:0]};
   assign imm8Ext  = ctrl.zeroExt ? {8'h00, instr[7:0]}   : {{8{instr[7]}}, instr[7:0]};
   // Jump displacement is always signed
   assign imm11Ext = {{5{instr[10]}}, instr[10:0]};

   // Pick the destination field for this format
   always_comb begin
      case (ctrl.dstSel)
         isaPkg::dstRd: dstIdx = instr[4:2];
         isaPkg::dstRs: dstIdx = instr[10:8];
         isaPkg::dstRt: dstIdx = instr[7:5];
         default:       dstIdx = isaPkg::linkReg;
      endcase
   end

   ////////////////////////////////////////////////////////////
   // Decode register
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         slotQ <= '0;
      end else begin
         // Bubbles advance as invalid slots
         slotQ.valid  <= instrIn.valid;
         slotQ.pc     <= instrIn.pc;
         slotQ.ctrl   <= ctrl;
         slotQ.rsIdx  <= instr[10:8];
         slotQ.rtIdx  <= instr[7:5];
         slotQ.dstIdx <= dstIdx;
         // Operand data is filled from the register file on the way out
         slotQ.rsData <= '0;
         slotQ.rtData <= '0;
         slotQ.imm5   <= imm5Ext;
         slotQ.imm8   <= imm8Ext;
         slotQ.imm11  <= imm11Ext;
      end
   end

   // Read with the registered indexes
   // A result retired at this edge is then already in the file
   assign rdIdxA = slotQ.rsIdx;
   assign rdIdxB = slotQ.rtIdx;

   always_comb begin
      decoded        = slotQ;
      decoded.rsData = rdDataA;
      decoded.rtData = rdDataB;
   end

endmodule

`default_nettype wire

/* logic/aluUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
   input  isaPkg::aluOpT               op,
   input  logic [isaPkg::dataW-1:0]    a,
   input  logic [isaPkg::dataW-1:0]    b,
   input  logic                        invA,
   input  logic                        invB,
   input  logic                        cin,
   output logic [isaPkg::dataW-1:0]    result
);

   logic [isaPkg::dataW-1:0]   opA;
   logic [isaPkg::dataW-1:0]   opB;
   logic [isaPkg::dataW-1:0]   sum;
   logic                       carry;
   logic                       overflow;
   logic                       lessThan;
   logic                       equal;
   logic [3:0]                 shamt;
   logic [2*isaPkg::dataW-1:0] rolWide;
   logic [2*isaPkg::dataW-1:0] rorWide;

   ////////////////////////////////////////////////////////////
   // Adder with optional inversion
   ////////////////////////////////////////////////////////////
   assign opA = invA ? ~a : a;
   assign opB = invB ? ~b : b;
   assign {carry, sum} = {1'b0, opA} + {1'b0, opB} + {16'h0000, cin};

   // Signed overflow from operand and sum signs
   assign overflow = (opA[15] == opB[15]) && (sum[15] != opA[15]);
   // With B inverted the sum is a - b
   assign lessThan = sum[15] ^ overflow;
   assign equal    = (a == b);

   ////////////////////////////////////////////////////////////
   // Shifter
   ////////////////////////////////////////////////////////////
   // Only the low four bits of B count
   assign shamt   = b[3:0];
   // Rotates shift a doubled copy of A
   assign rolWide = {a, a} << shamt;
   assign rorWide = {a, a} >> shamt;

   always_comb begin
      case (op)
         isaPkg::aluAdd:   result = sum;
         isaPkg::aluXor:   result = a ^ b;
         isaPkg::aluAndn:  result = a & ~b;
         isaPkg::aluRol:   result = rolWide[31:16];
         isaPkg::aluSll:   result = a << shamt;
         isaPkg::aluRor:   result = rorWide[15:0];
         isaPkg::aluSrl:   result = a >> shamt;
         // Compares return 0 or 1
         isaPkg::aluSeq:   result = {15'h0000, equal};
         isaPkg::aluSlt:   result = {15'h0000, lessThan};
         isaPkg::aluSle:   result = {15'h0000, lessThan | equal};
         isaPkg::aluSco:   result = {15'h0000, carry};
         isaPkg::aluPassB: result = b;
         default:          result = sum;
      endcase
   end

endmodule

`default_nettype wire

/* logic/executeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module executeStage (
   input  logic             clk,
   input  logic             rstN,
   input  isaPkg::decodedT  decoded,
   output isaPkg::wbT       wbOut,
   output isaPkg::redirectT redirectOut,
   output logic             unsupportedOut
);

   isaPkg::ctrlT             ctrl;
   logic [isaPkg::dataW-1:0] rsVal;
   logic [isaPkg::dataW-1:0] rtVal;
   logic [isaPkg::dataW-1:0] bOperand;
   logic [isaPkg::dataW-1:0] aluResult;
   logic [isaPkg::dataW-1:0] revRs;
   logic [isaPkg::dataW-1:0] linkAddr;
   logic [isaPkg::dataW-1:0] wbData;
   logic                     taken;

   assign ctrl = decoded.ctrl;

   ////////////////////////////////////////////////////////////
   // Operand forwarding and B select
   ////////////////////////////////////////////////////////////
   // Previous result overrides a stale register read
   assign rsVal = (wbOut.valid && wbOut.regIdx == decoded.rsIdx) ? wbOut.data : decoded.rsData;
   assign rtVal = (wbOut.valid && wbOut.regIdx == decoded.rtIdx) ? wbOut.data : decoded.rtData;

   always_comb begin
      case (ctrl.bSrc)
         isaPkg::bRegRt: bOperand = rtVal;
         isaPkg::bImm5:  bOperand = decoded.imm5;
         isaPkg::bImm8:  bOperand = decoded.imm8;
         // SLBI, imm8 arrives zero-extended
         default:        bOperand = {rsVal[7:0], 8'h00} | decoded.imm8;
      endcase
   end

   aluUnit uAlu (
      .op     (ctrl.aluOp),
      .a      (rsVal),
      .b      (bOperand),
      .invA   (ctrl.invA),
      .invB   (ctrl.invB),
      .cin    (ctrl.cin),
      .result (aluResult)
   );

   assign revRs    = {<<{rsVal}};
   assign linkAddr = decoded.pc + 16'd2;

   always_comb begin
      case (ctrl.wbSrc)
         isaPkg::wbLink: wbData = linkAddr;
         isaPkg::wbRev:  wbData = revRs;
         default:        wbData = aluResult;
      endcase
   end

   ////////////////////////////////////////////////////////////
   // Branch resolution
   ////////////////////////////////////////////////////////////
   always_comb begin
      case (ctrl.brCond)
         isaPkg::brEqz:    taken = (rsVal == '0);
         isaPkg::brNez:    taken = (rsVal != '0);
         isaPkg::brLtz:    taken = rsVal[15];
         isaPkg::brGez:    taken = !rsVal[15];
         isaPkg::brAlways,
         isaPkg::brReg:    taken = 1'b1;
         default:          taken = 1'b0;
      endcase
   end

   // JR and JALR are Rs-relative, the rest are PC+2 relative
   assign redirectOut.valid  = decoded.valid && taken;
   assign redirectOut.target = (ctrl.brCond == isaPkg::brReg) ? rsVal + decoded.imm8 :
                               linkAddr + (ctrl.longImm ? decoded.imm11 : decoded.imm8);
   assign unsupportedOut     = decoded.valid && ctrl.unsupported;

   // Write-back register, also feeds the register file write port
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         wbOut <= '0;
      end else begin
         wbOut.valid  <= decoded.valid && ctrl.regWrt;
         wbOut.regIdx <= decoded.dstIdx;
         wbOut.data   <= wbData;
      end
   end

   // The decoder keeps control transfers and unsupported ops apart
   noRedirectOnUnsup: assert property (@(posedge clk) disable iff (!rstN)
      !(redirectOut.valid && unsupportedOut));

endmodule

`default_nettype wire

/* logic/coreTop.sv */
`timescale 1ns/1ps
`default_nettype none

module coreTop (
   input  logic             clk,
   input  logic             rstN,
   input  isaPkg::instrInT  instrIn,
   output isaPkg::wbT       wbOut,
   output isaPkg::redirectT redirectOut,
   output logic             unsupportedOut
);

   logic [isaPkg::regIdxW-1:0] rdIdxA;
   logic [isaPkg::regIdxW-1:0] rdIdxB;
   logic [isaPkg::dataW-1:0]   rdDataA;
   logic [isaPkg::dataW-1:0]   rdDataB;
   isaPkg::decodedT            decoded;

   ////////////////////////////////////////////////////////////
   // Decode, register file, execute
   ////////////////////////////////////////////////////////////
   decodeStage uDecode (
      .clk     (clk),
      .rstN    (rstN),
      .instrIn (instrIn),
      .rdIdxA  (rdIdxA),
      .rdIdxB  (rdIdxB),
      .rdDataA (rdDataA),
      .rdDataB (rdDataB),
      .decoded (decoded)
   );

   // Written straight from the registered write-back
   regFile uRegs (
      .clk     (clk),
      .rstN    (rstN),
      .rdIdxA  (rdIdxA),
      .rdIdxB  (rdIdxB),
      .rdDataA (rdDataA),
      .rdDataB (rdDataB),
      .wr      (wbOut)
   );

   executeStage uExec (
      .clk            (clk),
      .rstN           (rstN),
      .decoded        (decoded),
      .wbOut          (wbOut),
      .redirectOut    (redirectOut),
      .unsupportedOut (unsupportedOut)
   );

endmodule

`default_nettype wire

/* bench/coreTable.svh */
// Each call adds one slot: encoded instruction, then expected write or redirect
// Slot addresses start at 0x00fe and step by 2
function automatic void loadFixedRows();
   // All registers read zero out of reset
   regResult(regForm(isaPkg::opRformat, 3'd5, 3'd6, 3'd7, 2'b00), 3'd7, 16'h0000);

   ////////////////////////////////////////////////////////////
   // Immediate and register ALU ops
   ////////////////////////////////////////////////////////////
   regResult(byteForm(isaPkg::opLbi, 3'd1, 8'h35), 3'd1, 16'h0035);
   // Uses r1 from the slot before
   regResult(immForm(isaPkg::opAddi, 3'd1, 3'd2, 5'h1d), 3'd2, 16'h0032);
   // imm - Rs, r1 now from the register file
   regResult(immForm(isaPkg::opSubi, 3'd1, 3'd3, 5'h04), 3'd3, 16'hffcf);
   regResult(immForm(isaPkg::opXori, 3'd1, 3'd4, 5'h1f), 3'd4, 16'h002a);
   regResult(immForm(isaPkg::opAndni, 3'd3, 3'd5, 5'h1c), 3'd5, 16'hffc3);
   regResult(regForm(isaPkg::opRformat, 3'd1, 3'd2, 3'd6, 2'b00), 3'd6, 16'h0067);
   // Rt - Rs
   regResult(regForm(isaPkg::opRformat, 3'd1, 3'd2, 3'd7, 2'b01), 3'd7, 16'hfffd);
   regResult(regForm(isaPkg::opRformat, 3'd4, 3'd5, 3'd6, 2'b10), 3'd6, 16'hffe9);
   regResult(regForm(isaPkg::opRformat, 3'd3, 3'd1, 3'd2, 2'b11), 3'd2, 16'hffca);

   // Shifts and rotates
   regResult(immForm(isaPkg::opRoli, 3'd5, 3'd1, 5'd4), 3'd1, 16'hfc3f);
   regResult(immForm(isaPkg::opSlli, 3'd4, 3'd2, 5'd3), 3'd2, 16'h0150);
   regResult(immForm(isaPkg::opRori, 3'd1, 3'd3, 5'd8), 3'd3, 16'h3ffc);
   regResult(immForm(isaPkg::opSrli, 3'd6, 3'd4, 5'd5), 3'd4, 16'h07ff);
   // Amounts from Rt bits 3..0, 13 then 15
   regResult(regForm(isaPkg::opRshift, 3'd1, 3'd7, 3'd5, 2'b10), 3'd5, 16'he1ff);
   regResult(regForm(isaPkg::opRshift, 3'd4, 3'd5, 3'd6, 2'b01), 3'd6, 16'h8000);
   regResult(regForm(isaPkg::opSeq, 3'd4, 3'd4, 3'd7, 2'b00), 3'd7, 16'h0001);

   ////////////////////////////////////////////////////////////
   // Byte loads, bit reverse and links
   ////////////////////////////////////////////////////////////
   regResult(byteForm(isaPkg::opLbi, 3'd1, 8'h9a), 3'd1, 16'hff9a);
   regResult(byteForm(isaPkg::opSlbi, 3'd1, 8'h5c), 3'd1, 16'h9a5c);
   regResult(regForm(isaPkg::opBtr, 3'd1, 3'd0, 3'd2, 2'b00), 3'd2, 16'h3a59);
   linkJump(jumpForm(isaPkg::opJal, 11'h010), 16'h0128, 16'h0138);
   // Target is r2 + 4
   linkJump(byteForm(isaPkg::opJalr, 3'd2, 8'h04), 16'h012a, 16'h3a5d);

   // Branches on Rs, target PC+2 plus imm8
   branch(byteForm(isaPkg::opBeqz, 3'd0, 8'hf0), 1'b1, 16'h011c);
   branch(byteForm(isaPkg::opBnez, 3'd0, 8'h10), 1'b0, 16'h0000);
   branch(byteForm(isaPkg::opBltz, 3'd1, 8'h08), 1'b1, 16'h0138);
   branch(byteForm(isaPkg::opBgez, 3'd1, 8'h08), 1'b0, 16'h0000);
   branch(byteForm(isaPkg::opBgez, 3'd2, 8'h7f), 1'b1, 16'h01b3);
   branch(jumpForm(isaPkg::opJ, 11'h7fc), 1'b1, 16'h0132);
   branch(byteForm(isaPkg::opJr, 3'd7, 8'h02), 1'b1, 16'h012c);
   branch(byteForm(isaPkg::opBnez, 3'd7, 8'h80), 1'b1, 16'h00ba);

   // Memory ops, bubbles and idle ops
   unsupportedOp(immForm(isaPkg::opSt, 3'd1, 3'd2, 5'h00));
   bubble(jumpForm(isaPkg::opJal, 11'h020));
   unsupportedOp(immForm(isaPkg::opLd, 3'd3, 3'd4, 5'h02));
   noEffect(jumpForm(isaPkg::opNop, 11'h000));
   noEffect(jumpForm(isaPkg::opHalt, 11'h000));
   unsupportedOp(immForm(isaPkg::opStu, 3'd5, 3'd6, 5'h01));
endfunction

/* bench/coreBench.sv */
`timescale 1ns/1ps
`default_nettype none

module coreBench;

   // One program slot with the results it must produce
   typedef struct packed {
      isaPkg::instrInT  slot;
      isaPkg::wbT       expWb;
      isaPkg::redirectT expRedirect;
      logic             expUnsup;
   } rowT;

   logic             clk;
   logic             rstN;
   isaPkg::instrInT  instrIn;
   isaPkg::wbT       wbOut;
   isaPkg::redirectT redirectOut;
   logic             unsupportedOut;

   rowT         rows[$];
   logic [15:0] nextPc;
   logic [31:0] lfsrState;
   int          cycleCount = 0;
   int          cycleLimit = 0;

   coreTop dut (
      .clk            (clk),
      .rstN           (rstN),
      .instrIn        (instrIn),
      .wbOut          (wbOut),
      .redirectOut    (redirectOut),
      .unsupportedOut (unsupportedOut)
   );

   // 4 ns clock
   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   ////////////////////////////////////////////////////////////
   // Instruction encoders
   ////////////////////////////////////////////////////////////
   // Rs 10..8, result 7..5, imm5 4..0
   function automatic logic [15:0] immForm(input isaPkg::opcodeT op, input logic [2:0] rs,
                                           input logic [2:0] rd, input logic [4:0] imm);
      return {op, rs, rd, imm};
   endfunction

   // Rs 10..8, Rt 7..5, Rd 4..2, funct 1..0
   function automatic logic [15:0] regForm(input isaPkg::opcodeT op, input logic [2:0] rs,
                                           input logic [2:0] rt, input logic [2:0] rd,
                                           input logic [1:0] funct);
      return {op, rs, rt, rd, funct};
   endfunction

   // Rs 10..8, imm8 7..0
   function automatic logic [15:0] byteForm(input isaPkg::opcodeT op, input logic [2:0] rs,
                                            input logic [7:0] imm);
      return {op, rs, imm};
   endfunction

   function automatic logic [15:0] jumpForm(input isaPkg::opcodeT op, input logic [10:0] disp);
      return {op, disp};
   endfunction

   ////////////////////////////////////////////////////////////
   // Table building
   ////////////////////////////////////////////////////////////
   function automatic void appendRow(input logic valid, input logic [15:0] instr,
                                     input isaPkg::wbT wb, input isaPkg::redirectT redirect,
                                     input logic unsup);
      rowT row;
      row.slot.valid  = valid;
      row.slot.pc     = nextPc;
      row.slot.instr  = instr;
      row.expWb       = wb;
      row.expRedirect = redirect;
      row.expUnsup    = unsup;
      rows.push_back(row);
      // Addresses advance by one halfword per slot
      nextPc = nextPc + 16'd2;
   endfunction

   function automatic void regResult(input logic [15:0] instr, input logic [2:0] idx,
                                     input logic [15:0] data);
      appendRow(1'b1, instr, {1'b1, idx, data}, '0, 1'b0);
   endfunction

   // Conditional or plain transfer, never a write
   function automatic void branch(input logic [15:0] instr, input logic taken,
                                  input logic [15:0] target);
      appendRow(1'b1, instr, '0, {taken, target}, 1'b0);
   endfunction

   // JAL and JALR write r7 and redirect
   function automatic void linkJump(input logic [15:0] instr, input logic [15:0] data,
                                    input logic [15:0] target);
      appendRow(1'b1, instr, {1'b1, isaPkg::linkReg, data}, {1'b1, target}, 1'b0);
   endfunction

   function automatic void noEffect(input logic [15:0] instr);
      appendRow(1'b1, instr, '0, '0, 1'b0);
   endfunction

   function automatic void unsupportedOp(input logic [15:0] instr);
      appendRow(1'b1, instr, '0, '0, 1'b1);
   endfunction

   // Invalid slot, the word itself must be ignored
   function automatic void bubble(input logic [15:0] instr);
      appendRow(1'b0, instr, '0, '0, 1'b0);
   endfunction

   `include "coreTable.svh"

   ////////////////////////////////////////////////////////////
   // Random operands
   ////////////////////////////////////////////////////////////
   // Galois form, taps 32 22 2 1
   function automatic logic [31:0] lfsrStep(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   function automatic logic [15:0] takeBits();
      logic [15:0] val;
      val = '0;
      for (int i = 0; i < 16; i++) begin
         val = {val[14:0], lfsrState[0]};
         lfsrState = lfsrStep(lfsrState);
      end
      return val;
   endfunction

   // Load a and b through LBI and SLBI, then compare them
   function automatic void addCompareRows(input int sets);
      logic [15:0] a;
      logic [15:0] b;
      logic [16:0] sum;
      logic        lt;
      logic        le;
      for (int s = 0; s < sets; s++) begin
         a = takeBits();
         b = takeBits();
         // Last set compares a value with itself
         if (s == sets - 1) b = a;
         lt  = $signed(a) < $signed(b);
         le  = $signed(a) <= $signed(b);
         sum = {1'b0, a} + {1'b0, b};
         regResult(byteForm(isaPkg::opLbi, 3'd1, a[15:8]), 3'd1, {{8{a[15]}}, a[15:8]});
         regResult(byteForm(isaPkg::opSlbi, 3'd1, a[7:0]), 3'd1, a);
         regResult(byteForm(isaPkg::opLbi, 3'd2, b[15:8]), 3'd2, {{8{b[15]}}, b[15:8]});
         regResult(byteForm(isaPkg::opSlbi, 3'd2, b[7:0]), 3'd2, b);
         regResult(regForm(isaPkg::opSlt, 3'd1, 3'd2, 3'd3, 2'b00), 3'd3, {15'd0, lt});
         regResult(regForm(isaPkg::opSle, 3'd1, 3'd2, 3'd4, 2'b00), 3'd4, {15'd0, le});
         regResult(regForm(isaPkg::opSco, 3'd1, 3'd2, 3'd5, 2'b00), 3'd5, {15'd0, sum[16]});
      end
   endfunction

   ////////////////////////////////////////////////////////////
   // Compare tasks
   ////////////////////////////////////////////////////////////
   // Index and data only count for a valid write
   task automatic checkWb(input string name, input isaPkg::wbT act, input isaPkg::wbT exp);
      if (act.valid !== exp.valid ||
          (exp.valid && (act.regIdx !== exp.regIdx || act.data !== exp.data))) begin
         $display("Mismatch at %0t ns: %s expected %h got %h", $time, name, exp, act);
         $display("** FAIL **");
         $fatal(1);
      end
   endtask

   task automatic checkRedirect(input string name, input isaPkg::redirectT act,
                                input isaPkg::redirectT exp);
      if (act.valid !== exp.valid || (exp.valid && act.target !== exp.target)) begin
         $display("Mismatch at %0t ns: %s expected %h got %h", $time, name, exp, act);
         $display("** FAIL **");
         $fatal(1);
      end
   endtask

   task automatic checkFlag(input string name, input logic act, input logic exp);
      if (act !== exp) begin
         $display("Mismatch at %0t ns: %s expected %b got %b", $time, name, exp, act);
         $display("** FAIL **");
         $fatal(1);
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Stimulus and checking
   ////////////////////////////////////////////////////////////
   initial begin : stimulus
      rstN      = 1'b0;
      instrIn   = '0;
      nextPc    = 16'h00fe;
      lfsrState = 32'hc2ab_3b88;
      loadFixedRows();
      addCompareRows(4);
      cycleLimit = rows.size() + 10;

      // Outputs stay quiet while reset is held
      @(posedge clk);
      @(negedge clk);
      checkWb("wbOut in reset", wbOut, '0);
      checkRedirect("redirectOut in reset", redirectOut, '0);
      checkFlag("unsupportedOut in reset", unsupportedOut, 1'b0);
      @(posedge clk);
      rstN <= 1'b1;

      // Row c is accepted one edge after it is driven
      // Redirect and unsupported show one cycle later, the write one more
      for (int c = 0; c < rows.size() + 2; c++) begin
         @(posedge clk);
         if (c < rows.size()) instrIn <= rows[c].slot;
         else instrIn <= '0;
         @(negedge clk);
         if (c >= 1) begin
            checkRedirect($sformatf("redirectOut, row %0d", c - 1), redirectOut,
                          rows[c-1].expRedirect);
            checkFlag($sformatf("unsupportedOut, row %0d", c - 1), unsupportedOut,
                      rows[c-1].expUnsup);
         end else begin
            checkRedirect("redirectOut after reset", redirectOut, '0);
            checkFlag("unsupportedOut after reset", unsupportedOut, 1'b0);
         end
         if (c >= 2) checkWb($sformatf("wbOut, row %0d", c - 2), wbOut, rows[c-2].expWb);
         else checkWb("wbOut after reset", wbOut, '0);
      end

      $display("** PASS **");
      $finish;
   end

   // Watchdog on the cycle count
   always @(posedge clk) begin
      cycleCount = cycleCount + 1;
      if (cycleLimit > 0 && cycleCount > cycleLimit) begin
         $display("Timeout: the program did not finish within %0d cycles", cycleLimit);
         $display("** FAIL **");
         $fatal(1);
      end
   end

endmodule

`default_nettype wire

/* files.f */
+incdir+bench
logic/isaPkg.sv
logic/controlDecoder.sv
logic/regFile.sv
logic/decodeStage.sv
logic/aluUnit.sv
logic/executeStage.sv
logic/coreTop.sv
bench/coreBench.sv

/* run.sh */
#!/usr/bin/env bash
# Build with Verilator and run, the exit status follows the testbench
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f files.f --top-module coreBench -Mdir obj_dir &&
./obj_dir/VcoreBench || exit 1
